//--- Bender.yml
package:
  name: rob_subsys

sources:
  # packages first, then the rtl
  - verilog/rv32i_types_pkg.sv
  - verilog/rob_pkg.sv
  - verilog/dispatch_unit.sv
  - verilog/rob.sv
  - verilog/commit_unit.sv
  - verilog/rob_subsys_top.sv

  - target: test
    files:
      - dv/clk_rst_gen.sv
      - dv/rob_subsys_tb.sv

//--- dv/clk_rst_gen.sv
`timescale 1ns/1ps

module clk_rst_gen #(
    parameter int PERIOD_NS  = 8,
    parameter int RST_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_o
);

    // free running clock
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    // reset held for a fixed number of edges, released just after an edge
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1;
        rst_o = 1'b0;
    end

endmodule

//--- dv/rob_subsys_tb.sv
`timescale 1ns/1ps

module rob_subsys_tb #(
    parameter int ROB_DEPTH  = 32,
    parameter int NUM_RANDOM = 300
);
    import rv32i_types_pkg::*;
    import rob_pkg::*;

    localparam rob_cnt_t FULL_CNT    = rob_cnt_t'(ROB_DEPTH);
    localparam int       DRAIN_LIMIT = 4 * ROB_DEPTH + 40;

    // one dispatched instruction per record with the oldest at the front
    typedef struct {
        pc_t        pc;
        reg_addr_t  rd;
        rob_idx_t   idx;
        xlen_data_t data;
    } disp_rec_t;

    logic        clk;
    logic        rst;
    logic        dispatch_valid_i;
    pc_t         dispatch_pc_i;
    inst_t       dispatch_inst_i;
    logic        dispatch_ready_o;
    rob_idx_t    dispatch_rob_idx_o;
    logic        cdb_alu_valid_i;
    rob_idx_t    cdb_alu_idx_i;
    xlen_data_t  cdb_alu_data_i;
    logic        cdb_mul_valid_i;
    rob_idx_t    cdb_mul_idx_i;
    xlen_data_t  cdb_mul_data_i;
    logic        commit_valid_o;
    pc_t         commit_pc_o;
    reg_addr_t   commit_rd_o;
    xlen_data_t  commit_data_o;
    reg_addr_t   rf_raddr_i;
    xlen_data_t  rf_rdata_o;
    rob_cnt_t    rob_count_o;

    // scoreboard
    disp_rec_t   order_q[$];
    rob_idx_t    wait_q[$];
    fu_class_t   fu_of   [ROB_DEPTH];
    rob_idx_t    exp_idx;
    pc_t         next_pc;
    logic [31:0] lcg_state;
    logic        rf_follow;

    // oldest two uncommitted entries for the latency assertions
    logic        front_valid;
    rob_idx_t    front_idx;
    logic        second_valid;
    rob_idx_t    second_idx;

    // dut outputs seen at the falling edge of the last cycle
    logic        snap_ready;
    rob_cnt_t    snap_count;
    logic        snap_commit;
    xlen_data_t  snap_rdata;

    logic        head_hit;
    logic        pair_hit;

    clk_rst_gen #(
        .PERIOD_NS  (8),
        .RST_CYCLES (10)
    ) u_clk_rst (
        .clk_o (clk),
        .rst_o (rst)
    );

    rob_subsys_top #(
        .ROB_DEPTH (ROB_DEPTH)
    ) uut (
        .clk                (clk),
        .rst                (rst),
        .dispatch_valid_i   (dispatch_valid_i),
        .dispatch_pc_i      (dispatch_pc_i),
        .dispatch_inst_i    (dispatch_inst_i),
        .dispatch_ready_o   (dispatch_ready_o),
        .dispatch_rob_idx_o (dispatch_rob_idx_o),
        .cdb_alu_valid_i    (cdb_alu_valid_i),
        .cdb_alu_idx_i      (cdb_alu_idx_i),
        .cdb_alu_data_i     (cdb_alu_data_i),
        .cdb_mul_valid_i    (cdb_mul_valid_i),
        .cdb_mul_idx_i      (cdb_mul_idx_i),
        .cdb_mul_data_i     (cdb_mul_data_i),
        .commit_valid_o     (commit_valid_o),
        .commit_pc_o        (commit_pc_o),
        .commit_rd_o        (commit_rd_o),
        .commit_data_o      (commit_data_o),
        .rf_raddr_i         (rf_raddr_i),
        .rf_rdata_o         (rf_rdata_o),
        .rob_count_o        (rob_count_o)
    );

    task automatic report_fail(string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_value(string name, logic [31:0] expected, logic [31:0] actual);
        report_fail($sformatf("ERROR %s expected 0x%08h actual 0x%08h", name, expected, actual));
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(int n);
        return int'((lcg_next() >> 8) % 32'(n));
    endfunction

    // reference decode from the unit class rule
    function automatic fu_class_t ref_fu(inst_t w);
        if (w[6:0] == OPC_OP && w[31:25] == FUNCT7_MULDIV) begin
            return fu_mul;
        end
        if (w[6:0] inside {OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR,
                           OPC_LOAD}) begin
            return fu_alu;
        end
        return fu_none;
    endfunction

    // random instruction with OP weighted up so the mul group shows often
    function automatic inst_t make_inst();
        inst_t w;
        w = lcg_next();
        case (rand_below(10))
            0, 1:    w[6:0] = OPC_OP;
            2:       w[6:0] = OPC_OP_IMM;
            3:       w[6:0] = OPC_LUI;
            4:       w[6:0] = OPC_AUIPC;
            5:       w[6:0] = OPC_JAL;
            6:       w[6:0] = OPC_JALR;
            7:       w[6:0] = OPC_LOAD;
            8:       w[6:0] = OPC_STORE;
            default: w[6:0] = OPC_BRANCH;
        endcase
        if (w[6:0] == OPC_OP) begin
            w[31:25] = (rand_below(2) == 1) ? FUNCT7_MULDIV : 7'b0000000;
        end
        // some writes aimed at x0
        if (rand_below(8) == 0) begin
            w[11:7] = 5'd0;
        end
        return w;
    endfunction

    function automatic void refresh_front();
        front_valid  = (order_q.size() > 0);
        front_idx    = front_valid ? order_q[0].idx : '0;
        second_valid = (order_q.size() > 1);
        second_idx   = second_valid ? order_q[1].idx : '0;
    endfunction

    task automatic offer_inst(inst_t w);
        dispatch_pc_i    = next_pc;
        dispatch_inst_i  = w;
        dispatch_valid_i = 1'b1;
        next_pc          = next_pc + 32'd4;
    endtask

    // one clock cycle entered and left 1 ns after a rising edge
    task automatic run_cycle(output logic accepted);
        disp_rec_t rec;
        @(negedge clk);
        accepted    = dispatch_valid_i && dispatch_ready_o;
        snap_ready  = dispatch_ready_o;
        snap_count  = rob_count_o;
        snap_commit = commit_valid_o;
        snap_rdata  = rf_rdata_o;
        if (accepted) begin
            assert (dispatch_rob_idx_o === exp_idx)
                else report_value("dispatch_rob_idx_o", exp_idx, dispatch_rob_idx_o);
        end
        @(posedge clk);
        #1;
        cdb_alu_valid_i = 1'b0;
        cdb_mul_valid_i = 1'b0;
        if (accepted) begin
            rec.pc   = dispatch_pc_i;
            rec.idx  = exp_idx;
            rec.rd   = (ref_fu(dispatch_inst_i) == fu_none) ? '0 : dispatch_inst_i[11:7];
            rec.data = '0;
            fu_of[exp_idx] = ref_fu(dispatch_inst_i);
            order_q.push_back(rec);
            wait_q.push_back(exp_idx);
            refresh_front();
            exp_idx = (exp_idx == rob_idx_t'(ROB_DEPTH - 1)) ? '0 : exp_idx + 1'b1;
            dispatch_valid_i = 1'b0;
        end
    endtask

    task automatic dispatch_one(inst_t w);
        logic acc;
        int   guard;
        offer_inst(w);
        acc   = 1'b0;
        guard = 0;
        while (!acc) begin
            run_cycle(acc);
            guard++;
            if (!acc && guard > DRAIN_LIMIT) begin
                report_fail("timeout waiting for dispatch to be accepted");
            end
        end
    endtask

    // completion on the channel of the entry's unit class
    task automatic fire_index(rob_idx_t idx);
        xlen_data_t d;
        d = lcg_next();
        for (int p = 0; p < wait_q.size(); p++) begin
            if (wait_q[p] == idx) begin
                wait_q.delete(p);
                break;
            end
        end
        // the waiting entry is the newest record with this index
        for (int r = order_q.size() - 1; r >= 0; r--) begin
            if (order_q[r].idx == idx) begin
                order_q[r].data = d;
                break;
            end
        end
        if (fu_of[idx] == fu_mul) begin
            cdb_mul_valid_i = 1'b1;
            cdb_mul_idx_i   = idx;
            cdb_mul_data_i  = d;
        end else begin
            cdb_alu_valid_i = 1'b1;
            cdb_alu_idx_i   = idx;
            cdb_alu_data_i  = d;
        end
    endtask

    task automatic fire_random(bit both);
        int       pos;
        int       off;
        rob_idx_t first;
        pos   = rand_below(wait_q.size());
        first = wait_q[pos];
        fire_index(first);
        if (both && wait_q.size() > 0) begin
            // partner must use the other channel
            off = rand_below(wait_q.size());
            for (int k = 0; k < wait_q.size(); k++) begin
                pos = (off + k) % wait_q.size();
                if ((fu_of[wait_q[pos]] == fu_mul) != (fu_of[first] == fu_mul)) begin
                    fire_index(wait_q[pos]);
                    break;
                end
            end
        end
    endtask

    task automatic drain_all();
        logic acc;
        int   guard;
        guard = 0;
        while (order_q.size() > 0) begin
            if (wait_q.size() > 0) begin
                fire_random(rand_below(3) == 0);
            end
            run_cycle(acc);
            guard++;
            if (guard > DRAIN_LIMIT) begin
                report_fail("timeout waiting for the reorder buffer to drain");
            end
        end
    endtask

    // fill without completions and then free exactly one slot
    task automatic fill_and_release();
        logic acc;
        for (int i = 0; i < ROB_DEPTH; i++) begin
            dispatch_one(make_inst());
        end
        offer_inst(make_inst());
        run_cycle(acc);
        assert (!acc && snap_ready === 1'b0)
            else report_value("dispatch_ready_o", 0, snap_ready);
        assert (snap_count === FULL_CNT) else report_value("rob_count_o", FULL_CNT, snap_count);
        fire_index(order_q[0].idx);
        // completion edge with the head not done yet
        run_cycle(acc);
        assert (!acc) else report_fail("stalled dispatch went through before the head was done");
        run_cycle(acc);
        assert (acc) else report_fail("stalled dispatch not taken in the retirement cycle");
        assert (snap_count === FULL_CNT) else report_value("rob_count_o", FULL_CNT, snap_count);
        run_cycle(acc);
        assert (snap_commit === 1'b1) else report_value("commit_valid_o", 1, snap_commit);
        assert (snap_ready === 1'b0) else report_value("dispatch_ready_o", 0, snap_ready);
        assert (snap_count === FULL_CNT) else report_value("rob_count_o", FULL_CNT, snap_count);
    endtask

    // add then mul completed in the same cycle
    task automatic pair_test();
        logic acc;
        dispatch_one({7'b0000000, 5'd2, 5'd1, 3'b000, 5'd5, OPC_OP});
        dispatch_one({FUNCT7_MULDIV, 5'd4, 5'd3, 3'b000, 5'd6, OPC_OP});
        fire_index(order_q[0].idx);
        fire_index(order_q[1].idx);
        repeat (4) run_cycle(acc);
    endtask

    // register file read port follows the commit report
    always @(posedge clk) begin
        if (rf_follow) begin
            #1;
            rf_raddr_i = commit_rd_o;
        end
    end

    // in-order commit check against the scoreboard
    always @(negedge clk) begin : commit_check
        disp_rec_t  rec;
        xlen_data_t exp_rf;
        if (!rst && commit_valid_o === 1'b1) begin
            if (order_q.size() == 0) begin
                report_fail("commit reported with no instruction outstanding");
            end else begin
                rec = order_q.pop_front();
                refresh_front();
                exp_rf = (rec.rd == 5'd0) ? '0 : rec.data;
                assert (commit_pc_o === rec.pc)
                    else report_value("commit_pc_o", rec.pc, commit_pc_o);
                assert (commit_rd_o === rec.rd)
                    else report_value("commit_rd_o", rec.rd, commit_rd_o);
                assert (commit_data_o === rec.data)
                    else report_value("commit_data_o", rec.data, commit_data_o);
                assert (rf_rdata_o === exp_rf)
                    else report_value("rf_rdata_o", exp_rf, rf_rdata_o);
            end
        end
    end

    // cdb strobes on the oldest entries
    assign head_hit = front_valid &&
        ((cdb_alu_valid_i && cdb_alu_idx_i == front_idx) ||
         (cdb_mul_valid_i && cdb_mul_idx_i == front_idx));
    assign pair_hit = front_valid && second_valid && cdb_alu_valid_i && cdb_mul_valid_i &&
        ((cdb_alu_idx_i == front_idx && cdb_mul_idx_i == second_idx) ||
         (cdb_alu_idx_i == second_idx && cdb_mul_idx_i == front_idx));

    a_ready_not_full: assert property (
        @(posedge clk) disable iff (rst)
        rob_count_o != FULL_CNT |-> dispatch_ready_o
    ) else report_value("dispatch_ready_o", 1, $sampled(dispatch_ready_o));

    a_full_ready_retires: assert property (
        @(posedge clk) disable iff (rst)
        rob_count_o == FULL_CNT && dispatch_ready_o |=> commit_valid_o
    ) else report_value("commit_valid_o", 1, $sampled(commit_valid_o));

    a_count_max: assert property (
        @(posedge clk) disable iff (rst)
        rob_count_o <= FULL_CNT
    ) else report_value("rob_count_o", FULL_CNT, $sampled(rob_count_o));

    // head done at edge n gives a commit strobe sampled at edge n+2
    a_head_latency: assert property (
        @(posedge clk) disable iff (rst)
        head_hit |-> ##2 commit_valid_o
    ) else report_fail("completed head entry did not commit two cycles later");

    a_pair_b2b: assert property (
        @(posedge clk) disable iff (rst)
        pair_hit |-> ##2 commit_valid_o ##1 commit_valid_o
    ) else report_fail("two oldest entries completed together did not commit back to back");

    initial begin : stimulus
        logic acc;
        int   guard;
        int   sent;
        lcg_state        = 32'd21;
        dispatch_valid_i = 1'b0;
        dispatch_pc_i    = '0;
        dispatch_inst_i  = '0;
        cdb_alu_valid_i  = 1'b0;
        cdb_alu_idx_i    = '0;
        cdb_alu_data_i   = '0;
        cdb_mul_valid_i  = 1'b0;
        cdb_mul_idx_i    = '0;
        cdb_mul_data_i   = '0;
        rf_raddr_i       = '0;
        rf_follow        = 1'b0;
        exp_idx          = '0;
        next_pc          = 32'h0000_1000;
        refresh_front();

        guard = 0;
        while (rst !== 1'b0) begin
            @(posedge clk);
            guard++;
            if (guard > 50) begin
                report_fail("timeout waiting for reset to be released");
            end
        end
        #1;

        // state after reset and a sweep of the register file
        for (int a = 0; a < 32; a++) begin
            rf_raddr_i = reg_addr_t'(a);
            run_cycle(acc);
            if (a == 0) begin
                assert (snap_ready === 1'b1) else report_value("dispatch_ready_o", 1, snap_ready);
                assert (snap_commit === 1'b0) else report_value("commit_valid_o", 0, snap_commit);
                assert (snap_count === '0) else report_value("rob_count_o", 0, snap_count);
            end
            assert (snap_rdata === '0) else report_value("rf_rdata_o", 0, snap_rdata);
        end
        rf_follow = 1'b1;

        fill_and_release();
        drain_all();
        pair_test();
        drain_all();

        // random mix with completions out of order
        sent  = 0;
        guard = 0;
        while (sent < NUM_RANDOM || order_q.size() > 0) begin
            if (!dispatch_valid_i && sent < NUM_RANDOM && rand_below(4) != 0) begin
                offer_inst(make_inst());
            end
            if (wait_q.size() > 0 && rand_below(3) != 0) begin
                fire_random(rand_below(4) == 0);
            end
            run_cycle(acc);
            if (acc) begin
                sent++;
            end
            guard++;
            if (guard > 20 * NUM_RANDOM + DRAIN_LIMIT) begin
                report_fail("timeout in the random phase");
            end
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- rob_subsys_top.f
verilog/rv32i_types_pkg.sv
verilog/rob_pkg.sv
verilog/dispatch_unit.sv
verilog/rob.sv
verilog/commit_unit.sv
verilog/rob_subsys_top.sv
dv/clk_rst_gen.sv
dv/rob_subsys_tb.sv

//--- verilog/commit_unit.sv
`timescale 1ns/1ps

module commit_unit (
    input  logic                        clk,
    input  logic                        rst,

    // head entry of the rob
    input  logic                        head_done_i,
    input  rv32i_types_pkg::pc_t        head_pc_i,
    input  rv32i_types_pkg::reg_addr_t  head_rd_i,
    input  rv32i_types_pkg::xlen_data_t head_data_i,
    output logic                        retire_o,

    // retirement report
    output logic                        commit_valid_o,
    output rv32i_types_pkg::pc_t        commit_pc_o,
    output rv32i_types_pkg::reg_addr_t  commit_rd_o,
    output rv32i_types_pkg::xlen_data_t commit_data_o,

    // architectural register file read port
    input  rv32i_types_pkg::reg_addr_t  rf_raddr_i,
    output rv32i_types_pkg::xlen_data_t rf_rdata_o
);
    import rv32i_types_pkg::*;

    localparam int NUM_REGS = 32;

    // architectural state with x0 never written
    xlen_data_t rf_q [NUM_REGS];

    // commit never stalls so a done head always leaves
    assign retire_o = head_done_i;

    // combinational read port
    // x0 keeps its reset value of zero
    assign rf_rdata_o = rf_q[rf_raddr_i];

    // register file write at the retiring edge
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                rf_q[i] <= '0;
            end
        end else if (retire_o && (head_rd_i != '0)) begin
            rf_q[head_rd_i] <= head_data_i;
        end
    end

    // one commit strobe per retired entry
    always_ff @(posedge clk) begin
        if (rst) begin
            commit_valid_o <= 1'b0;
        end else begin
            commit_valid_o <= retire_o;
        end
    end

    // report payload only meaningful with the strobe
    always_ff @(posedge clk) begin
        if (retire_o) begin
            commit_pc_o   <= head_pc_i;
            commit_rd_o   <= head_rd_i;
            commit_data_o <= head_data_i;
        end
    end

    // a done head must carry a known payload
    a_head_known: assert property (
        @(posedge clk) disable iff (rst)
        head_done_i |-> !$isunknown({head_pc_i, head_rd_i, head_data_i})
    ) else $error("commit_unit: done head entry with unknown payload");

endmodule

//--- verilog/dispatch_unit.sv
`timescale 1ns/1ps

module dispatch_unit #(
    parameter int ROB_DEPTH = 32
) (
    input  logic                        clk,
    input  logic                        rst,

    // from the front end, one instruction per transfer
    input  logic                        dispatch_valid_i,
    input  rv32i_types_pkg::pc_t        dispatch_pc_i,
    input  rv32i_types_pkg::inst_t      dispatch_inst_i,
    output logic                        dispatch_ready_o,
    output rob_pkg::rob_idx_t           dispatch_rob_idx_o,

    // allocation request towards the rob
    output logic                        alloc_valid_o,
    output rv32i_types_pkg::pc_t        alloc_pc_o,
    output rv32i_types_pkg::reg_addr_t  alloc_rd_o,
    output rv32i_types_pkg::fu_class_t  alloc_fu_o,
    input  logic                        alloc_ready_i,
    input  rob_pkg::rob_idx_t           alloc_idx_i
);
    import rv32i_types_pkg::*;
    import rob_pkg::*;

    logic [6:0] opcode;
    logic [6:0] funct7;
    reg_addr_t  rd_field;
    fu_class_t  fu_class;

    // depth must be a power of two that the index can address
    if ((ROB_DEPTH < 2) || (ROB_DEPTH > (1 << ROB_IDX_W)) ||
        ((ROB_DEPTH & (ROB_DEPTH - 1)) != 0)) begin : g_bad_depth
        $error("dispatch_unit: ROB_DEPTH must be a power of two from 2 to 32");
    end

    // instruction fields
    assign opcode   = dispatch_inst_i[6:0];
    assign funct7   = dispatch_inst_i[31:25];
    assign rd_field = dispatch_inst_i[11:7];

    // functional unit class
    always_comb begin
        case (opcode)
            OPC_OP: begin
                // mul group shares the OP opcode, split on funct7
                fu_class = (funct7 == FUNCT7_MULDIV) ? fu_mul : fu_alu;
            end
            OPC_OP_IMM, OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_LOAD: begin
                fu_class = fu_alu;
            end
            OPC_STORE, OPC_BRANCH: begin
                fu_class = fu_none;
            end
            // fence and anything unknown retire without a write
            default: begin
                fu_class = fu_none;
            end
        endcase
    end

    // handshake goes straight to the rob, which owns the full test
    assign alloc_valid_o      = dispatch_valid_i;
    assign alloc_pc_o         = dispatch_pc_i;
    assign alloc_fu_o         = fu_class;
    // rd field of stores and branches is really imm bits
    assign alloc_rd_o         = (fu_class == fu_none) ? '0 : rd_field;
    assign dispatch_ready_o   = alloc_ready_i;
    // slot the offered instruction lands in
    assign dispatch_rob_idx_o = alloc_idx_i;

    // a stalled request must not change under the stall
    a_dispatch_stable: assert property (
        @(posedge clk) disable iff (rst)
        dispatch_valid_i && !dispatch_ready_o |=>
            !dispatch_valid_i || ($stable(dispatch_pc_i) && $stable(dispatch_inst_i))
    ) else $error("dispatch_unit: pc or instruction changed while stalled");

endmodule

//--- verilog/rob.sv
`timescale 1ns/1ps

module rob #(
    parameter int ROB_DEPTH = 32
) (
    input  logic                        clk,
    input  logic                        rst,

    // allocation from dispatch
    input  logic                        alloc_valid_i,
    input  rv32i_types_pkg::pc_t        alloc_pc_i,
    input  rv32i_types_pkg::reg_addr_t  alloc_rd_i,
    input  rv32i_types_pkg::fu_class_t  alloc_fu_i,
    output logic                        alloc_ready_o,
    output rob_pkg::rob_idx_t           alloc_idx_o,

    // cdb, alu channel
    input  logic                        cdb_alu_valid_i,
    input  rob_pkg::rob_idx_t           cdb_alu_idx_i,
    input  rv32i_types_pkg::xlen_data_t cdb_alu_data_i,

    // cdb, multiplier channel
    input  logic                        cdb_mul_valid_i,
    input  rob_pkg::rob_idx_t           cdb_mul_idx_i,
    input  rv32i_types_pkg::xlen_data_t cdb_mul_data_i,

    // head entry towards commit
    output logic                        head_done_o,
    output rv32i_types_pkg::pc_t        head_pc_o,
    output rv32i_types_pkg::reg_addr_t  head_rd_o,
    output rv32i_types_pkg::xlen_data_t head_data_o,
    input  logic                        retire_i,

    output rob_pkg::rob_cnt_t           count_o
);
    import rv32i_types_pkg::*;
    import rob_pkg::*;

    localparam rob_idx_t LAST_IDX = rob_idx_t'(ROB_DEPTH - 1);
    localparam rob_cnt_t FULL_CNT = rob_cnt_t'(ROB_DEPTH);

    // entry table, status is control, the rest is payload
    rob_status_t status_q [ROB_DEPTH];
    pc_t         pc_q     [ROB_DEPTH];
    reg_addr_t   rd_q     [ROB_DEPTH];
    fu_class_t   fu_q     [ROB_DEPTH];
    xlen_data_t  data_q   [ROB_DEPTH];

    rob_idx_t    head_q;
    rob_idx_t    tail_q;
    rob_cnt_t    count_q;

    logic        full;
    logic        insert;
    logic        remove;

    assign full   = (count_q == FULL_CNT);
    // a full buffer still takes one in the cycle the head leaves
    assign alloc_ready_o = !full || retire_i;
    assign insert = alloc_valid_i && alloc_ready_o;
    // commit only retires a done head, so the buffer is not empty here
    assign remove = retire_i && (status_q[head_q] == rob_done);

    assign alloc_idx_o = tail_q;
    assign count_o     = count_q;

    // head view for commit
    assign head_done_o = (status_q[head_q] == rob_done);
    assign head_pc_o   = pc_q[head_q];
    assign head_data_o = data_q[head_q];
    // no destination without a unit class
    assign head_rd_o   = (fu_q[head_q] == fu_none) ? '0 : rd_q[head_q];

    // status, pointers and count
    always_ff @(posedge clk) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                status_q[i] <= rob_empty;
            end
        end else begin
            // completions, by index only
            if (cdb_alu_valid_i) begin
                status_q[cdb_alu_idx_i] <= rob_done;
            end
            if (cdb_mul_valid_i) begin
                status_q[cdb_mul_idx_i] <= rob_done;
            end

            // retirement frees the head slot
            if (remove) begin
                status_q[head_q] <= rob_empty;
                head_q <= (head_q == LAST_IDX) ? '0 : head_q + 1'b1;
            end

            // allocation last, full case reuses the slot freed above
            if (insert) begin
                status_q[tail_q] <= rob_wait;
                tail_q <= (tail_q == LAST_IDX) ? '0 : tail_q + 1'b1;
            end

            case ({insert, remove})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // payload fields
    always_ff @(posedge clk) begin
        if (insert) begin
            pc_q[tail_q] <= alloc_pc_i;
            rd_q[tail_q] <= alloc_rd_i;
            fu_q[tail_q] <= alloc_fu_i;
        end
        if (cdb_alu_valid_i) begin
            data_q[cdb_alu_idx_i] <= cdb_alu_data_i;
        end
        if (cdb_mul_valid_i) begin
            data_q[cdb_mul_idx_i] <= cdb_mul_data_i;
        end
    end

    // cdb may only complete an outstanding entry
    a_alu_cdb_wait: assert property (
        @(posedge clk) disable iff (rst)
        cdb_alu_valid_i |-> status_q[cdb_alu_idx_i] == rob_wait
    ) else $error("rob: alu cdb names an entry that is not waiting");

    a_mul_cdb_wait: assert property (
        @(posedge clk) disable iff (rst)
        cdb_mul_valid_i |-> status_q[cdb_mul_idx_i] == rob_wait
    ) else $error("rob: mul cdb names an entry that is not waiting");

    // both channels on one slot would lose a result
    a_cdb_distinct: assert property (
        @(posedge clk) disable iff (rst)
        cdb_alu_valid_i && cdb_mul_valid_i |-> cdb_alu_idx_i != cdb_mul_idx_i
    ) else $error("rob: both cdb channels name the same index");

    a_count_bound: assert property (
        @(posedge clk) disable iff (rst)
        count_q <= FULL_CNT
    ) else $error("rob: count above depth");

endmodule

//--- verilog/rob_pkg.sv
package rob_pkg;

    // index width; the widest buffer is 2**ROB_IDX_W entries
    localparam int ROB_IDX_W = 5;

    // slot number inside the reorder buffer
    typedef logic [ROB_IDX_W-1:0] rob_idx_t;

    // occupancy, one bit wider so a full buffer fits
    typedef logic [ROB_IDX_W:0] rob_cnt_t;

    // per-entry state
    // rob_empty  slot is free
    // rob_wait   allocated, result not back yet
    // rob_done   result captured from the cdb, ready to retire
    typedef enum logic [1:0] {
        rob_empty,
        rob_wait,
        rob_done
    } rob_status_t;

endpackage

//--- verilog/rob_subsys_top.sv
`timescale 1ns/1ps

module rob_subsys_top #(
    parameter int ROB_DEPTH = 32
) (
    input  logic                        clk,
    input  logic                        rst,

    // dispatch handshake
    input  logic                        dispatch_valid_i,
    input  rv32i_types_pkg::pc_t        dispatch_pc_i,
    input  rv32i_types_pkg::inst_t      dispatch_inst_i,
    output logic                        dispatch_ready_o,
    output rob_pkg::rob_idx_t           dispatch_rob_idx_o,

    // cdb channels
    input  logic                        cdb_alu_valid_i,
    input  rob_pkg::rob_idx_t           cdb_alu_idx_i,
    input  rv32i_types_pkg::xlen_data_t cdb_alu_data_i,
    input  logic                        cdb_mul_valid_i,
    input  rob_pkg::rob_idx_t           cdb_mul_idx_i,
    input  rv32i_types_pkg::xlen_data_t cdb_mul_data_i,

    // commit report
    output logic                        commit_valid_o,
    output rv32i_types_pkg::pc_t        commit_pc_o,
    output rv32i_types_pkg::reg_addr_t  commit_rd_o,
    output rv32i_types_pkg::xlen_data_t commit_data_o,

    // register file read, occupancy
    input  rv32i_types_pkg::reg_addr_t  rf_raddr_i,
    output rv32i_types_pkg::xlen_data_t rf_rdata_o,
    output rob_pkg::rob_cnt_t           rob_count_o
);
    import rv32i_types_pkg::*;
    import rob_pkg::*;

    // dispatch to rob
    logic       alloc_valid;
    pc_t        alloc_pc;
    reg_addr_t  alloc_rd;
    fu_class_t  alloc_fu;
    logic       alloc_ready;
    rob_idx_t   alloc_idx;

    // rob to commit
    logic       head_done;
    pc_t        head_pc;
    reg_addr_t  head_rd;
    xlen_data_t head_data;
    logic       retire;

    dispatch_unit #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_dispatch (
        .clk                (clk),
        .rst                (rst),
        .dispatch_valid_i   (dispatch_valid_i),
        .dispatch_pc_i      (dispatch_pc_i),
        .dispatch_inst_i    (dispatch_inst_i),
        .dispatch_ready_o   (dispatch_ready_o),
        .dispatch_rob_idx_o (dispatch_rob_idx_o),
        .alloc_valid_o      (alloc_valid),
        .alloc_pc_o         (alloc_pc),
        .alloc_rd_o         (alloc_rd),
        .alloc_fu_o         (alloc_fu),
        .alloc_ready_i      (alloc_ready),
        .alloc_idx_i        (alloc_idx)
    );

    rob #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_rob (
        .clk             (clk),
        .rst             (rst),
        .alloc_valid_i   (alloc_valid),
        .alloc_pc_i      (alloc_pc),
        .alloc_rd_i      (alloc_rd),
        .alloc_fu_i      (alloc_fu),
        .alloc_ready_o   (alloc_ready),
        .alloc_idx_o     (alloc_idx),
        .cdb_alu_valid_i (cdb_alu_valid_i),
        .cdb_alu_idx_i   (cdb_alu_idx_i),
        .cdb_alu_data_i  (cdb_alu_data_i),
        .cdb_mul_valid_i (cdb_mul_valid_i),
        .cdb_mul_idx_i   (cdb_mul_idx_i),
        .cdb_mul_data_i  (cdb_mul_data_i),
        .head_done_o     (head_done),
        .head_pc_o       (head_pc),
        .head_rd_o       (head_rd),
        .head_data_o     (head_data),
        .retire_i        (retire),
        .count_o         (rob_count_o)
    );

    commit_unit u_commit (
        .clk            (clk),
        .rst            (rst),
        .head_done_i    (head_done),
        .head_pc_i      (head_pc),
        .head_rd_i      (head_rd),
        .head_data_i    (head_data),
        .retire_o       (retire),
        .commit_valid_o (commit_valid_o),
        .commit_pc_o    (commit_pc_o),
        .commit_rd_o    (commit_rd_o),
        .commit_data_o  (commit_data_o),
        .rf_raddr_i     (rf_raddr_i),
        .rf_rdata_o     (rf_rdata_o)
    );

endmodule

//--- verilog/rv32i_types_pkg.sv
package rv32i_types_pkg;

    // register values and cdb payload
    typedef logic [31:0] xlen_data_t;

    // program counter
    typedef logic [31:0] pc_t;

    // raw instruction word
    typedef logic [31:0] inst_t;

    // architectural register number, x0..x31
    typedef logic [4:0] reg_addr_t;

    // which unit executes the instruction
    // fu_none for branches, stores and fence, which have no destination
    typedef enum logic [1:0] {
        fu_none,
        fu_alu,
        fu_mul
    } fu_class_t;

    // major opcodes, inst[6:0]
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // funct7 of the multiply group under OPC_OP
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

endpackage
